// File: common/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ====================================================================
// Cache geometry
// ====================================================================
`define DC_XLEN        32   // Word and address width
`define DC_LINE_WORDS  8    // Words per line
`define DC_N_WAYS      4    // Associativity
`define DC_N_SETS      16   // Kept small so evictions come early
`define DC_BYTE_BITS   2    // Byte offset within a word

// Derived field widths
`define DC_WORD_BITS   $clog2(`DC_LINE_WORDS)
`define DC_SET_BITS    $clog2(`DC_N_SETS)
`define DC_WAY_BITS    $clog2(`DC_N_WAYS)

// Address field positions
// tag | set | word | byte
`define DC_SET_LSB     (`DC_BYTE_BITS + `DC_WORD_BITS)
`define DC_TAG_LSB     (`DC_SET_LSB + `DC_SET_BITS)
`define DC_TAG_BITS    (`DC_XLEN - `DC_TAG_LSB)

// Whole line as one vector
`define DC_LINE_BITS   (`DC_XLEN * `DC_LINE_WORDS)

`endif

// File: common/dcache_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    // ====================================================================
    // Vector types
    // ====================================================================
    typedef logic [`DC_XLEN-1:0]        word_t;      // One processor word
    typedef logic [`DC_XLEN-1:0]        addr_t;      // Byte address
    typedef word_t [`DC_LINE_WORDS-1:0] line_t;      // Word 0 in the low bits
    typedef logic [`DC_TAG_BITS-1:0]    tag_t;
    typedef logic [`DC_SET_BITS-1:0]    set_idx_t;
    typedef logic [`DC_WAY_BITS-1:0]    way_idx_t;
    typedef logic [`DC_WORD_BITS-1:0]   word_off_t;  // Word within a line
    typedef logic [`DC_XLEN/8-1:0]      byte_en_t;

    // ====================================================================
    // Request bundles
    // ====================================================================
    // Processor request, one word
    typedef struct packed {
        logic     we;     // 1 for store
        byte_en_t be;     // Bytes written on a store
        addr_t    addr;
        word_t    wdata;
    } cpu_req_t;

    // Memory request, one whole line
    typedef struct packed {
        logic  we;        // 1 for write-back
        addr_t addr;      // Line aligned
        line_t wdata;     // Victim line on write-back
    } mem_req_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        REFILL,
        REFILL_DONE
    } dc_state_e;

endpackage

`default_nettype wire

// File: logic/sram_1rw.sv
`timescale 1ns/100ps
`default_nettype none

module sram_1rw #(
    parameter int WIDTH = 32,     // Bits per entry
    parameter int DEPTH = 16      // Entries
) (
    input  wire                     clk_i,
    input  wire                     we_i,
    input  wire [$clog2(DEPTH)-1:0] addr_i,
    input  wire [WIDTH-1:0]         data_i,
    output logic [WIDTH-1:0]        data_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Single port, read returns old contents on a write
    always_ff @(posedge clk_i)
    begin
        if (we_i)
            mem[addr_i] <= data_i;
        data_o <= mem[addr_i];   // Registered read
    end

endmodule

`default_nettype wire

// File: dcache/dcache_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_tag_store (
    input  wire                       clk_i,
    input  wire                       rst_i,
    input  wire dcache_pkg::set_idx_t lookup_set_i,
    input  wire dcache_pkg::tag_t     req_tag_i,
    input  wire                       fill_en_i,         // Refill completes
    input  wire                       mark_dirty_en_i,   // Store hit
    input  wire                       write_is_store_i,
    input  wire dcache_pkg::way_idx_t way_i,
    output logic                      hit_o,
    output dcache_pkg::way_idx_t      hit_way_o,
    output dcache_pkg::way_idx_t      victim_way_o,
    output logic                      victim_dirty_o,
    output dcache_pkg::tag_t          victim_tag_o
);
    import dcache_pkg::*;

    // Bookkeeping bits per set and way
    logic [`DC_N_SETS-1:0][`DC_N_WAYS-1:0] valid_q;
    logic [`DC_N_SETS-1:0][`DC_N_WAYS-1:0] dirty_q;
    way_idx_t [`DC_N_SETS-1:0]             fifo_q;   // Next way to replace

    tag_t                  tag_rd [`DC_N_WAYS];
    logic [`DC_N_WAYS-1:0] way_hit;

    // ====================================================================
    // Tag RAMs and compare
    // ====================================================================
    for (genvar w = 0; w < `DC_N_WAYS; w++)
    begin : g_way
        sram_1rw #(
            .WIDTH (`DC_TAG_BITS),
            .DEPTH (`DC_N_SETS)
        ) i_tag_ram (
            .clk_i  (clk_i),
            .we_i   (fill_en_i && (way_i == way_idx_t'(w))),   // Tag only on refill
            .addr_i (lookup_set_i),
            .data_i (req_tag_i),
            .data_o (tag_rd[w])
        );

        assign way_hit[w] = valid_q[lookup_set_i][w] && (tag_rd[w] == req_tag_i);
    end

    assign hit_o = |way_hit;

    // At most one way matches
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < `DC_N_WAYS; w++)
        begin
            if (way_hit[w])
                hit_way_o = way_idx_t'(w);
        end
    end

    // FIFO victim of the looked-up set
    assign victim_way_o   = fifo_q[lookup_set_i];
    assign victim_dirty_o = dirty_q[lookup_set_i][victim_way_o];
    assign victim_tag_o   = tag_rd[victim_way_o];

    // ====================================================================
    // Valid, dirty and FIFO pointers
    // ====================================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            fifo_q  <= '0;
        end
        else if (fill_en_i)
        begin
            valid_q[lookup_set_i][way_i] <= 1'b1;
            dirty_q[lookup_set_i][way_i] <= write_is_store_i;   // Write miss merged in
            fifo_q[lookup_set_i]         <= fifo_q[lookup_set_i] + 1'b1;
        end
        else if (mark_dirty_en_i)
            dirty_q[lookup_set_i][way_i] <= 1'b1;
    end

endmodule

`default_nettype wire

// File: dcache/dcache_data_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_data_store (
    input  wire                       clk_i,
    input  wire dcache_pkg::set_idx_t lookup_set_i,
    input  wire dcache_pkg::cpu_req_t req_i,           // Held request
    input  wire dcache_pkg::way_idx_t way_i,           // Hit or victim way
    input  wire                       hit_write_en_i,
    input  wire                       fill_en_i,
    input  wire                       capture_en_i,
    input  wire dcache_pkg::line_t    m_rdata_i,
    output dcache_pkg::word_t         rdata_o,
    output dcache_pkg::line_t         victim_line_o
);
    import dcache_pkg::*;

    line_t     line_rd [`DC_N_WAYS];   // One line per way
    line_t     refill_q;               // Line from memory
    line_t     sel_line;
    line_t     base_line;
    line_t     wr_line;
    word_t     base_word;
    word_t     merged_word;
    word_off_t off;

    assign off = req_i.addr[`DC_SET_LSB-1:`DC_BYTE_BITS];

    // ====================================================================
    // Refill buffer
    // ====================================================================
    always_ff @(posedge clk_i)
    begin
        if (capture_en_i)
            refill_q <= m_rdata_i;
    end

    // ====================================================================
    // Word select and byte merge
    // ====================================================================
    assign sel_line  = line_rd[way_i];
    assign base_line = fill_en_i ? refill_q : sel_line;   // Refill or hit line
    assign base_word = base_line[off];

    always_comb
    begin
        for (int b = 0; b < `DC_XLEN/8; b++)
        begin
            // Keep old byte unless enabled
            if (req_i.be[b])
                merged_word[8*b +: 8] = req_i.wdata[8*b +: 8];
            else
                merged_word[8*b +: 8] = base_word[8*b +: 8];
        end
    end

    // Store word lands in the line being written
    always_comb
    begin
        wr_line = base_line;
        if (req_i.we)
            wr_line[off] = merged_word;
    end

    assign rdata_o       = base_word;
    assign victim_line_o = sel_line;    // Victim way on a miss

    // ====================================================================
    // Line RAMs
    // ====================================================================
    for (genvar w = 0; w < `DC_N_WAYS; w++)
    begin : g_way
        sram_1rw #(
            .WIDTH (`DC_LINE_BITS),
            .DEPTH (`DC_N_SETS)
        ) i_line_ram (
            .clk_i  (clk_i),
            .we_i   ((hit_write_en_i || fill_en_i) && (way_i == way_idx_t'(w))),
            .addr_i (lookup_set_i),
            .data_i (wr_line),
            .data_o (line_rd[w])
        );
    end

endmodule

`default_nettype wire

// File: dcache/dcache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
    input  wire                       clk_i,
    input  wire                       rst_i,
    // Processor side
    input  wire                       p_strobe_i,
    input  wire dcache_pkg::cpu_req_t p_req_i,
    output logic                      p_ready_o,
    output dcache_pkg::word_t         p_rdata_o,
    // Memory side
    output logic                      m_strobe_o,
    output dcache_pkg::mem_req_t      m_req_o,
    input  wire                       m_ready_i,
    // From tag store
    input  wire                       hit_i,
    input  wire dcache_pkg::way_idx_t hit_way_i,
    input  wire dcache_pkg::way_idx_t victim_way_i,
    input  wire                       victim_dirty_i,
    input  wire dcache_pkg::tag_t     victim_tag_i,
    // From data store
    input  wire dcache_pkg::line_t    victim_line_i,
    input  wire dcache_pkg::word_t    rdata_i,
    // To storage
    output dcache_pkg::cpu_req_t      req_o,
    output dcache_pkg::set_idx_t      lookup_set_o,
    output dcache_pkg::way_idx_t      way_o,
    output logic                      hit_write_en_o,
    output logic                      fill_en_o,
    output logic                      capture_en_o
);
    import dcache_pkg::*;

    dc_state_e state_q;
    dc_state_e state_d;
    cpu_req_t  req_q;          // Held for the whole request
    mem_req_t  m_req_q;
    mem_req_t  wb_req;         // Victim write-back
    mem_req_t  rf_req;         // Line refill
    logic      m_strobe_q;
    logic      lookup_hit;

    // ====================================================================
    // FSM
    // ====================================================================
    assign lookup_hit = (state_q == LOOKUP) && hit_i;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (p_strobe_i)
                    state_d = LOOKUP;
            LOOKUP:
                if (hit_i)
                    state_d = IDLE;
                else if (victim_dirty_i)
                    state_d = WRITE_BACK;    // Dirty victim goes out first
                else
                    state_d = REFILL;
            WRITE_BACK:
                if (m_ready_i)
                    state_d = REFILL;
            REFILL:
                if (m_ready_i)
                    state_d = REFILL_DONE;
            REFILL_DONE:
                state_d = IDLE;              // Line written this cycle
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    // Request captured once, on the accepted strobe
    always_ff @(posedge clk_i)
    begin
        if (state_q == IDLE && p_strobe_i)
            req_q <= p_req_i;
    end

    // Incoming set while idle so RAMs are read at the strobe edge
    assign lookup_set_o = (state_q == IDLE) ? p_req_i.addr[`DC_TAG_LSB-1:`DC_SET_LSB]
                                            : req_q.addr[`DC_TAG_LSB-1:`DC_SET_LSB];

    assign way_o          = lookup_hit ? hit_way_i : victim_way_i;
    assign hit_write_en_o = lookup_hit && req_q.we;
    assign fill_en_o      = (state_q == REFILL_DONE);
    assign capture_en_o   = (state_q == REFILL) && m_ready_i;
    assign req_o          = req_q;

    // ====================================================================
    // Processor response
    // ====================================================================
    assign p_ready_o = lookup_hit || (state_q == REFILL_DONE);
    assign p_rdata_o = (p_ready_o && !req_q.we) ? rdata_i : '0;   // Zero for stores

    // ====================================================================
    // Memory request
    // ====================================================================
    always_comb
    begin
        wb_req.we    = 1'b1;
        wb_req.addr  = {victim_tag_i, req_q.addr[`DC_TAG_LSB-1:`DC_SET_LSB],
                        {`DC_SET_LSB{1'b0}}};
        wb_req.wdata = victim_line_i;
        rf_req.we    = 1'b0;
        rf_req.addr  = {req_q.addr[`DC_XLEN-1:`DC_SET_LSB], {`DC_SET_LSB{1'b0}}};
        rf_req.wdata = '0;
    end

    // Held steady while the strobe is up
    always_ff @(posedge clk_i)
    begin
        if (state_q == LOOKUP && !hit_i)
            m_req_q <= victim_dirty_i ? wb_req : rf_req;
        else if (state_q == WRITE_BACK && m_ready_i)
            m_req_q <= rf_req;               // Refill follows write-back
    end

    // Strobe drops the cycle after ready, refill strobe one cycle later
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            m_strobe_q <= 1'b0;
        else
        begin
            case (state_q)
                LOOKUP:     m_strobe_q <= !hit_i;
                WRITE_BACK: m_strobe_q <= !m_ready_i;
                REFILL:     m_strobe_q <= !m_ready_i;
                default:    m_strobe_q <= 1'b0;
            endcase
        end
    end

    assign m_strobe_o = m_strobe_q;
    assign m_req_o    = m_req_q;

endmodule

`default_nettype wire

// File: dcache/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
    input  wire                   clk_i,
    input  wire                   rst_i,
    // Processor side
    input  wire                   p_strobe_i,
    input  wire dcache_pkg::cpu_req_t p_req_i,
    output logic                  p_ready_o,
    output dcache_pkg::word_t     p_rdata_o,
    // Memory side
    output logic                  m_strobe_o,
    output dcache_pkg::mem_req_t  m_req_o,
    input  wire                   m_ready_i,
    input  wire dcache_pkg::line_t m_rdata_i
);
    import dcache_pkg::*;

    // Controller to storage
    cpu_req_t req;             // Registered request
    set_idx_t lookup_set;
    way_idx_t way;             // Hit way or victim way
    logic     hit_write_en;
    logic     fill_en;
    logic     capture_en;

    // Tag store results
    logic     hit;
    way_idx_t hit_way;
    way_idx_t victim_way;
    logic     victim_dirty;
    tag_t     victim_tag;

    // Data store results
    word_t    rdata;
    line_t    victim_line;

    // ====================================================================
    // Controller
    // ====================================================================
    dcache_ctrl i_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .p_strobe_i     (p_strobe_i),
        .p_req_i        (p_req_i),
        .p_ready_o      (p_ready_o),
        .p_rdata_o      (p_rdata_o),
        .m_strobe_o     (m_strobe_o),
        .m_req_o        (m_req_o),
        .m_ready_i      (m_ready_i),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_line_i  (victim_line),
        .rdata_i        (rdata),
        .req_o          (req),
        .lookup_set_o   (lookup_set),
        .way_o          (way),
        .hit_write_en_o (hit_write_en),
        .fill_en_o      (fill_en),
        .capture_en_o   (capture_en)
    );

    // ====================================================================
    // Storage
    // ====================================================================
    dcache_tag_store i_tag_store (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .lookup_set_i     (lookup_set),
        .req_tag_i        (req.addr[`DC_XLEN-1:`DC_TAG_LSB]),  // Tag of held request
        .fill_en_i        (fill_en),
        .mark_dirty_en_i  (hit_write_en),                      // Store hit dirties line
        .write_is_store_i (req.we),
        .way_i            (way),
        .hit_o            (hit),
        .hit_way_o        (hit_way),
        .victim_way_o     (victim_way),
        .victim_dirty_o   (victim_dirty),
        .victim_tag_o     (victim_tag)
    );

    dcache_data_store i_data_store (
        .clk_i          (clk_i),
        .lookup_set_i   (lookup_set),
        .req_i          (req),
        .way_i          (way),
        .hit_write_en_i (hit_write_en),
        .fill_en_i      (fill_en),
        .capture_en_i   (capture_en),
        .m_rdata_i      (m_rdata_i),
        .rdata_o        (rdata),
        .victim_line_o  (victim_line)
    );

endmodule

`default_nettype wire

// File: test/tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module tb_mem_model (
    input  wire                       clk_i,
    input  wire                       rst_i,
    input  wire                       strobe_i,
    input  wire dcache_pkg::mem_req_t req_i,
    output logic                      ready_o,
    output dcache_pkg::line_t         rdata_o
);
    import dcache_pkg::*;

    line_t       lines [addr_t];   // Lines written back so far
    logic [31:0] lfsr_q;
    mem_req_t    cur;              // Request being served
    logic [2:0]  delay_bits;
    int          wait_n;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    // Contents before any write, from the whole word address
    function automatic word_t fill_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h96e1_3c5a;
    endfunction

    function automatic line_t read_line(input addr_t a);
        line_t l;
        if (lines.exists(a))
            return lines[a];
        for (int i = 0; i < `DC_LINE_WORDS; i++)
            l[i] = fill_word(a + 4 * i);   // Word 0 in the low bits
        return l;
    endfunction

    // ====================================================================
    // Request service, driven on the falling edge
    // ====================================================================
    initial
    begin
        ready_o = 1'b0;
        rdata_o = '0;
        lfsr_q  = 32'hd4c8_55bd;
        forever
        begin
            @(negedge clk_i);
            if (strobe_i && !rst_i)
            begin
                cur = req_i;
                for (int b = 0; b < 3; b++)
                begin
                    lfsr_q        = lfsr_next(lfsr_q);
                    delay_bits[b] = lfsr_q[0];   // One step per bit
                end
                wait_n = int'(delay_bits) + 1;   // 1 to 8 cycles
                repeat (wait_n - 1) @(negedge clk_i);
                if (cur.we)
                    lines[cur.addr] = cur.wdata;
                else
                    rdata_o = read_line(cur.addr);
                ready_o = 1'b1;
                @(negedge clk_i);
                ready_o = 1'b0;   // Strobe is low again by now
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int MISS_CYCLES = 24;   // Worst write-back plus refill
    localparam int N_RANDOM    = 300;
    localparam int N_REQUESTS  = N_RANDOM + 40;

    logic        clk;
    logic        rst;
    logic        p_strobe;
    cpu_req_t    p_req;
    logic        p_ready;
    word_t       p_rdata;
    logic        m_strobe;
    mem_req_t    m_req;
    logic        m_ready;
    line_t       m_rdata;

    logic [7:0]  shadow [addr_t];      // Every byte stored so far
    logic [31:0] lfsr_q;
    int          cycles;               // Strobe to p_ready_o
    logic        saw_rd;
    logic        saw_wr;
    mem_req_t    wb_req;               // Write-back seen in last access
    word_t       rdata;

    dcache_top i_dcache_top (
        .clk_i      (clk),
        .rst_i      (rst),
        .p_strobe_i (p_strobe),
        .p_req_i    (p_req),
        .p_ready_o  (p_ready),
        .p_rdata_o  (p_rdata),
        .m_strobe_o (m_strobe),
        .m_req_o    (m_req),
        .m_ready_i  (m_ready),
        .m_rdata_i  (m_rdata)
    );

    tb_mem_model i_mem (
        .clk_i    (clk),
        .rst_i    (rst),
        .strobe_i (m_strobe),
        .req_i    (m_req),
        .ready_o  (m_ready),
        .rdata_o  (m_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v[i]   = lfsr_q[0];
        end
    endtask

    // Backing memory before any write
    function automatic word_t fill_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h96e1_3c5a;
    endfunction

    function automatic addr_t make_addr(input int tag, input int set, input int word);
        return {tag_t'(tag), set_idx_t'(set), word_off_t'(word), 2'b00};
    endfunction

    // First byte of the 32-byte line holding a
    function automatic addr_t line_base(input addr_t a);
        return a - (a % (4 * `DC_LINE_WORDS));
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        word_t w;
        w = fill_word(a);
        for (int b = 0; b < 4; b++)
            if (shadow.exists(a + b))
                w[8*b +: 8] = shadow[a + b];   // Stored bytes win
        return w;
    endfunction

    function automatic line_t expected_line(input addr_t a);
        line_t l;
        for (int i = 0; i < `DC_LINE_WORDS; i++)
            l[i] = shadow_word(a + 4 * i);
        return l;
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    // ====================================================================
    // One request from strobe to p_ready_o
    // ====================================================================
    task automatic access(input logic we, input byte_en_t be, input addr_t a,
                          input word_t wdata);
        @(negedge clk);
        p_req.we    = we;
        p_req.be    = be;
        p_req.addr  = a;
        p_req.wdata = wdata;
        p_strobe    = 1'b1;
        for (int b = 0; b < 4; b++)
            if (we && be[b])
                shadow[a + b] = wdata[8*b +: 8];
        saw_rd = 1'b0;
        saw_wr = 1'b0;
        cycles = 0;
        do
        begin
            @(negedge clk);
            p_strobe = 1'b0;
            cycles++;
            if (m_strobe && m_req.we)
            begin
                saw_wr = 1'b1;
                wb_req = m_req;
            end
            else if (m_strobe)
            begin
                saw_rd = 1'b1;
                assert (m_req.addr == line_base(a))   // Refill of the requested line
                else
                begin
                    $display("FAILED: m_req_o.addr = %h, expected %h",
                             m_req.addr, line_base(a));
                    abort_run();
                end
            end
            if (cycles > 2 * MISS_CYCLES)
            begin
                $display("Request to address %h got no p_ready_o in time", a);
                abort_run();
            end
        end while (!p_ready);
        rdata = p_rdata;
    endtask

    task automatic read_word(input addr_t a);
        access(1'b0, '0, a, '0);
        assert (rdata == shadow_word(a))
        else
        begin
            $display("FAILED: p_rdata_o = %h, expected %h at %h", rdata, shadow_word(a), a);
            abort_run();
        end
    endtask

    task automatic write_word(input addr_t a, input byte_en_t be, input word_t wdata);
        access(1'b1, be, a, wdata);
        assert (rdata == '0)
        else
        begin
            $display("FAILED: p_rdata_o = %h on a store, expected 0", rdata);
            abort_run();
        end
    endtask

    task automatic expect_hit();
        assert (cycles == 1 && !saw_rd && !saw_wr)
        else
        begin
            $display("Access to a resident line took %0d cycles or used memory", cycles);
            abort_run();
        end
    endtask

    task automatic expect_miss();
        assert (saw_rd)
        else
        begin
            $display("A miss was expected but no memory read strobe was seen");
            abort_run();
        end
    endtask

    // Sized for every request missing with a dirty victim
    initial
    begin
        #(N_REQUESTS * MISS_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        abort_run();
    end

    // ====================================================================
    // Directed and random tests
    // ====================================================================
    initial
    begin
        line_t       victim;
        logic [31:0] r_we;
        logic [31:0] r_set;
        logic [31:0] r_tag;
        logic [31:0] r_word;
        logic [31:0] r_be;
        logic [31:0] r_data;
        clk      = 1'b0;
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_req    = '0;
        lfsr_q   = 32'hd4c8_55bd;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!p_ready && !m_strobe)
        else
        begin
            $display("FAILED: p_ready_o = %h, m_strobe_o = %h after reset, expected 0",
                     p_ready, m_strobe);
            abort_run();
        end

        read_word(make_addr(1, 0, 3));   // Cold cache misses
        expect_miss();
        read_word(make_addr(1, 0, 6));   // Same line hits
        expect_hit();

        // Byte, half and full stores on miss and hit
        write_word(make_addr(2, 1, 2), 4'b0010, 32'hdead_beef);
        expect_miss();
        read_word(make_addr(2, 1, 2));
        expect_hit();
        write_word(make_addr(2, 1, 2), 4'b1100, 32'h1234_5678);
        expect_hit();
        read_word(make_addr(2, 1, 2));
        write_word(make_addr(2, 1, 2), 4'b0001, 32'hcafe_f00d);
        expect_hit();
        read_word(make_addr(2, 1, 2));
        write_word(make_addr(2, 1, 2), 4'b1111, 32'h0bad_c0de);
        expect_hit();
        read_word(make_addr(2, 1, 2));
        write_word(make_addr(3, 1, 5), 4'b0011, 32'h5555_aaaa);
        expect_miss();
        read_word(make_addr(3, 1, 5));
        read_word(make_addr(3, 1, 4));   // Rest of the refilled line
        write_word(make_addr(4, 1, 0), 4'b1111, 32'h7777_1111);
        expect_miss();
        read_word(make_addr(4, 1, 0));

        // Fifth tag in set 5 pushes out the first
        for (int t = 0; t < 5; t++)
            write_word(make_addr(10 + t, 5, t), 4'b1111, 32'h0a00_0000 + t);
        victim = expected_line(make_addr(10, 5, 0));
        expect_miss();
        assert (saw_wr)
        else
        begin
            $display("Dirty victim was not written back");
            abort_run();
        end
        assert (wb_req.addr == make_addr(10, 5, 0))
        else
        begin
            $display("FAILED: m_req_o.addr = %h, expected %h", wb_req.addr, make_addr(10, 5, 0));
            abort_run();
        end
        assert (wb_req.wdata == victim)
        else
        begin
            $display("FAILED: m_req_o.wdata = %h, expected %h", wb_req.wdata, victim);
            abort_run();
        end
        read_word(make_addr(11, 5, 0));   // Second tag still resident
        expect_hit();
        read_word(make_addr(10, 5, 0));
        expect_miss();

        // Clean lines leave without a write
        for (int t = 0; t < 5; t++)
            read_word(make_addr(20 + t, 7, 1));
        assert (saw_rd && !saw_wr)
        else
        begin
            $display("Replacing a clean line wrote memory or issued no read");
            abort_run();
        end

        // Eight tags over sets 8 to 11
        for (int i = 0; i < N_RANDOM; i++)
        begin
            take_bits(1, r_we);
            take_bits(2, r_set);
            take_bits(3, r_tag);
            take_bits(3, r_word);
            if (r_we[0])
            begin
                take_bits(4, r_be);
                take_bits(32, r_data);
                write_word(make_addr(30 + r_tag, 8 + r_set, r_word), r_be[3:0], r_data);
            end
            else
                read_word(make_addr(30 + r_tag, 8 + r_set, r_word));
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/dcache_pkg.sv
logic/sram_1rw.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_store.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run with Verilator, the exit status is the simulator's own
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        -f list.f --top-module tb_dcache -o tb_dcache \
    && ./obj_dir/tb_dcache \
    || exit 1
